// ==== design/idiv_iterative.sv ====
//----------------------------
// iterative restoring divider
// signed/unsigned, returns remainder and quotient together
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module idiv_iterative import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp,
  output logic          resp_val,
  input  logic          resp_rdy
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] LAST = `IMULDIV_CNT_W'(`IMULDIV_ITERS);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e                    state;
  logic [`IMULDIV_CNT_W-1:0] count;

  // partial remainder, quotient (starts as the dividend), divisor
  logic [XLEN-1:0] rem_reg;
  logic [XLEN-1:0] quo_reg;
  logic [XLEN-1:0] dvs_reg;
  // original dividend for the divide by zero result
  logic [XLEN-1:0] a_reg;
  logic            quo_neg;
  logic            rem_neg;
  logic            div_zero;
  imuldiv_resp_t   resp_reg;

  logic            req_go;
  logic            resp_go;
  logic            is_signed;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN:0]   rem_sh;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // magnitudes only for signed divide
  assign is_signed = (req.fn == FN_DIV);
  assign a_mag = (is_signed && req.a[XLEN-1]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[XLEN-1]) ? -req.b : req.b;

  // one restoring step, the top bit of diff is the borrow
  assign rem_sh = {rem_reg, quo_reg[XLEN-1]};
  assign diff   = rem_sh - {1'b0, dvs_reg};

  // sign fix, overflow case falls out as 0x80000000 rem 0
  assign quo_fix = quo_neg ? -quo_reg : quo_reg;
  assign rem_fix = rem_neg ? -rem_reg : rem_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      count    <= '0;
      rem_reg  <= '0;
      quo_reg  <= '0;
      dvs_reg  <= '0;
      a_reg    <= '0;
      quo_neg  <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
      resp_reg <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state    <= CALC;
            count    <= '0;
            rem_reg  <= '0;
            quo_reg  <= a_mag;
            dvs_reg  <= b_mag;
            a_reg    <= req.a;
            quo_neg  <= is_signed && (req.a[XLEN-1] ^ req.b[XLEN-1]);
            rem_neg  <= is_signed && req.a[XLEN-1];
            div_zero <= (req.b == '0);
          end
        end
        CALC: begin
          if (count == LAST) begin
            // wrap-up cycle registers the final response
            state <= DONE;
            if (div_zero) begin
              resp_reg.result <= {a_reg, {XLEN{1'b1}}};
            end else begin
              resp_reg.result <= {rem_fix, quo_fix};
            end
          end else begin
            count <= count + 1'b1;
            if (!diff[XLEN]) begin
              rem_reg <= diff[XLEN-1:0];
              quo_reg <= {quo_reg[XLEN-2:0], 1'b1};
            end else begin
              rem_reg <= rem_sh[XLEN-1:0];
              quo_reg <= {quo_reg[XLEN-2:0], 1'b0};
            end
          end
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
            count <= '0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign resp     = resp_reg;

endmodule

// ==== design/imul_iterative_ctrl.sv ====
//----------------------------
// iterative multiplier control
// idle/calc/done fsm, counts the shift-add steps
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module imul_iterative_ctrl import imuldiv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  output logic      resp_val,
  input  logic      resp_rdy,
  output mul_ctrl_t ctrl
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

  localparam logic [`IMULDIV_CNT_W-1:0] LAST = `IMULDIV_CNT_W'(`IMULDIV_ITERS);

  state_e                    state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                      req_go;
  logic                      resp_go;
  logic                      stepping;

  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  // shift on count 0..31, the count of 32 is the wrap-up cycle
  assign stepping = (state == CALC) && (count != LAST);

  //----------------------------
  // state and counter
  //----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (count == LAST) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // result held until the consumer takes it
          if (resp_go) begin
            state <= IDLE;
            count <= '0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //----------------------------
  // outputs
  //----------------------------
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // load on the handshake, shift while stepping
  assign ctrl.a_en      = req_go || stepping;
  assign ctrl.a_mux_sel = stepping;
  assign ctrl.b_en      = req_go || stepping;
  assign ctrl.b_mux_sel = stepping;

endmodule

// ==== design/imul_iterative_dpath.sv ====
//----------------------------
// iterative multiplier datapath
// shift-add over operand magnitudes, sign restored at the output
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module imul_iterative_dpath import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req,
  input  mul_ctrl_t     ctrl,
  output imuldiv_resp_t result
);

  localparam int XLEN = `IMULDIV_XLEN;

  // multiplicand grows left, multiplier drains right
  logic [2*XLEN-1:0] a_reg;
  logic [XLEN-1:0]   b_reg;
  logic [2*XLEN-1:0] acc_reg;
  logic              sign_reg;

  // operand magnitudes for the load
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  assign a_mag = req.a[XLEN-1] ? -req.a : req.a;
  assign b_mag = req.b[XLEN-1] ? -req.b : req.b;

  //----------------------------
  // multiplicand register
  //----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg <= '0;
    end else if (ctrl.a_en) begin
      if (ctrl.a_mux_sel) begin
        a_reg <= a_reg << 1;
      end else begin
        a_reg <= {{XLEN{1'b0}}, a_mag};
      end
    end
  end

  //----------------------------
  // multiplier, accumulator, sign
  //----------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      b_reg    <= '0;
      acc_reg  <= '0;
      sign_reg <= 1'b0;
    end else if (ctrl.b_en) begin
      if (ctrl.b_mux_sel) begin
        // add the current multiplicand when the low multiplier bit is set
        if (b_reg[0]) begin
          acc_reg <= acc_reg + a_reg;
        end
        b_reg <= b_reg >> 1;
      end else begin
        b_reg    <= b_mag;
        acc_reg  <= '0;
        // product is negative when exactly one operand is
        sign_reg <= req.a[XLEN-1] ^ req.b[XLEN-1];
      end
    end
  end

  // negate the magnitude product when needed
  assign result.result = sign_reg ? -acc_reg : acc_reg;

endmodule

// ==== design/imuldiv_cfg.svh ====
//----------------------------
// imuldiv configuration
// operand width and iteration count for the mul/div unit
//----------------------------

`ifndef IMULDIV_CFG_SVH
`define IMULDIV_CFG_SVH

// operand width, results are twice this wide
`define IMULDIV_XLEN 32

// iteration counter width, must hold the value of IMULDIV_ITERS
`define IMULDIV_CNT_W 6

// one shift/add or restoring step per bit of the operand
`define IMULDIV_ITERS `IMULDIV_XLEN

`endif

// ==== design/imuldiv_pkg.sv ====
//----------------------------
// imuldiv types
// function codes, request/response messages, multiplier controls
//----------------------------

`include "imuldiv_cfg.svh"

package imuldiv_pkg;

  // operation select carried with each request
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } imuldiv_fn_e;

  // request message, 66 bits
  typedef struct packed {
    imuldiv_fn_e               fn;
    logic [`IMULDIV_XLEN-1:0]  a;
    logic [`IMULDIV_XLEN-1:0]  b;
  } imuldiv_req_t;

  // response message
  // mul: full signed product
  // div: remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } imuldiv_resp_t;

  // multiplier fsm to datapath controls
  // *_mux_sel low loads the operands, high takes the shifted value
  typedef struct packed {
    logic a_en;
    logic a_mux_sel;
    logic b_en;
    logic b_mux_sel;
  } mul_ctrl_t;

endpackage

// ==== design/imuldiv_unit.sv ====
//----------------------------
// integer mul/div unit
// one operation in flight, steered to the multiplier or divider
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // outstanding operation and which unit owns it
  logic busy;
  logic owner_div;

  logic          sel_mul;
  logic          mul_req_val;
  logic          mul_req_rdy;
  logic          mul_resp_val;
  logic          mul_resp_rdy;
  mul_ctrl_t     mul_ctrl;
  imuldiv_resp_t mul_resp;
  logic          div_req_val;
  logic          div_req_rdy;
  logic          div_resp_val;
  logic          div_resp_rdy;
  imuldiv_resp_t div_resp;

  //----------------------------
  // request steering
  //----------------------------
  assign sel_mul     = (req.fn == FN_MUL);
  assign mul_req_val = req_val && !busy && sel_mul;
  assign div_req_val = req_val && !busy && !sel_mul;
  assign req_rdy     = !busy && (sel_mul ? mul_req_rdy : div_req_rdy);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_div <= !sel_mul;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  //----------------------------
  // response merge
  //----------------------------
  assign resp         = owner_div ? div_resp : mul_resp;
  assign resp_val     = busy && (owner_div ? div_resp_val : mul_resp_val);
  assign mul_resp_rdy = resp_rdy && busy && !owner_div;
  assign div_resp_rdy = resp_rdy && busy && owner_div;

  imul_iterative_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .ctrl     (mul_ctrl)
  );

  imul_iterative_dpath u_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ctrl   (mul_ctrl),
    .result (mul_resp)
  );

  idiv_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mul/div testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module imuldiv_tb -f sim.f -Mdir obj_dir -o imuldiv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/imuldiv_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== sim.f ====
+incdir+design
design/imuldiv_pkg.sv
design/imul_iterative_dpath.sv
design/imul_iterative_ctrl.sv
design/idiv_iterative.sv
design/imuldiv_unit.sv
tests/imuldiv_asserts.sv
tests/imuldiv_tb.sv

// ==== tests/imuldiv_asserts.sv ====
//----------------------------
// mul/div unit assertions
// valid/ready stability and idle after reset
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module imuldiv_asserts import imuldiv_pkg::*; (
  input logic          clk,
  input logic          reset,
  input imuldiv_req_t  req,
  input logic          req_val,
  input logic          req_rdy,
  input imuldiv_resp_t resp,
  input logic          resp_val,
  input logic          resp_rdy
);

  // request held while the unit is not ready
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> $stable(req))
    else $error("req changed while req_val was high and req_rdy low");

  // response held under back-pressure
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp))
    else $error("resp changed while resp_val was high and resp_rdy low");

  // one item in flight, never ready with a pending response
  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    !(resp_val && req_rdy))
    else $error("resp_val and req_rdy high together");

  a_reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

endmodule

// ==== tests/imuldiv_tb.sv ====
//----------------------------
// mul/div unit testbench
// table driven, reference results from the arithmetic rules
//----------------------------

`timescale 1ns/1ps

`include "imuldiv_cfg.svh"

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int XLEN    = `IMULDIV_XLEN;
  localparam int TIMEOUT = 100;

  // one stimulus row with its expected result and response hold-off
  typedef struct packed {
    imuldiv_fn_e       fn;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [2*XLEN-1:0] exp;
    logic [3:0]        hold;
  } tb_entry_t;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;

  tb_entry_t   table_q[$];
  logic [31:0] lfsr_state;
  int          err_count;
  int          err_before;
  int          failed_tests;
  logic        timed_out;

  imuldiv_unit u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  bind imuldiv_unit imuldiv_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  //----------------------------
  // random operands
  //----------------------------
  // galois step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  //----------------------------
  // reference model
  //----------------------------
  // mul gives the signed product, div gives {remainder, quotient}
  function automatic logic [2*XLEN-1:0] expected_result(input imuldiv_fn_e fn,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] prod;
    logic [XLEN-1:0]          q;
    logic [XLEN-1:0]          r;
    prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    if (fn == FN_MUL) begin
      return prod;
    end
    // divide by zero, quotient all ones and remainder is the dividend
    if (b == '0) begin
      return {a, {XLEN{1'b1}}};
    end
    if (fn == FN_DIVU) begin
      q = a / b;
      r = a % b;
    end else if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
      // most negative over minus one
      q = a;
      r = '0;
    end else begin
      // truncation toward zero, remainder follows the dividend
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end
    return {r, q};
  endfunction

  function automatic string fn_text(input imuldiv_fn_e fn);
    case (fn)
      FN_MUL:  return "mul ";
      FN_DIV:  return "div ";
      FN_DIVU: return "divu";
      default: return "????";
    endcase
  endfunction

  //----------------------------
  // compare tasks
  //----------------------------
  task automatic check_resp(input imuldiv_resp_t act, input imuldiv_resp_t exp,
                            input string name);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, act.result, exp.result);
      err_count++;
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string name);
    if (act !== exp) begin
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, act, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input int act, input int exp, input string name);
    if (act != exp) begin
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, act, exp);
      err_count++;
    end
  endtask

  task automatic report_timeout(input int idx, input string what);
    $display("test %0d timed out after %0d cycles waiting for %s", idx, TIMEOUT, what);
    timed_out = 1'b1;
  endtask

  //----------------------------
  // stimulus table
  //----------------------------
  function automatic void add_entry(input imuldiv_fn_e fn, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b, input logic [2*XLEN-1:0] exp,
                                    input logic [3:0] hold);
    tb_entry_t e;
    e.fn   = fn;
    e.a    = a;
    e.b    = b;
    e.exp  = exp;
    e.hold = hold;
    table_q.push_back(e);
  endfunction

  // hand computed corner cases
  function automatic void add_fixed_entries();
    add_entry(FN_MUL,  32'd7,         32'd6,         64'h0000_0000_0000_002A, 4'd0);
    add_entry(FN_MUL,  32'hFFFF_FFF9, 32'd6,         64'hFFFF_FFFF_FFFF_FFD6, 4'd3);
    add_entry(FN_MUL,  32'hFFFF_FFF9, 32'hFFFF_FFFA, 64'h0000_0000_0000_002A, 4'd0);
    add_entry(FN_MUL,  32'd0,         32'd12345,     64'h0000_0000_0000_0000, 4'd1);
    add_entry(FN_MUL,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 4'd0);
    add_entry(FN_MUL,  32'h8000_0000, 32'd1,         64'hFFFF_FFFF_8000_0000, 4'd2);
    add_entry(FN_MUL,  32'h7FFF_FFFF, 32'h7FFF_FFFF, 64'h3FFF_FFFF_0000_0001, 4'd0);
    add_entry(FN_MUL,  32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000, 4'd5);
    add_entry(FN_DIV,  32'd100,       32'd7,         64'h0000_0002_0000_000E, 4'd0);
    add_entry(FN_DIV,  32'hFFFF_FF9C, 32'd7,         64'hFFFF_FFFE_FFFF_FFF2, 4'd4);
    add_entry(FN_DIV,  32'd100,       32'hFFFF_FFF9, 64'h0000_0002_FFFF_FFF2, 4'd0);
    add_entry(FN_DIV,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 64'hFFFF_FFFE_0000_000E, 4'd1);
    add_entry(FN_DIVU, 32'hFFFF_FF9C, 32'd7,         64'h0000_0002_2492_4916, 4'd0);
    add_entry(FN_DIVU, 32'd100,       32'd7,         64'h0000_0002_0000_000E, 4'd2);
    // divide by zero and signed overflow
    add_entry(FN_DIV,  32'h1234_5678, 32'd0,         64'h1234_5678_FFFF_FFFF, 4'd0);
    add_entry(FN_DIV,  32'hFFFF_FFFB, 32'd0,         64'hFFFF_FFFB_FFFF_FFFF, 4'd3);
    add_entry(FN_DIVU, 32'hFFFF_FF9C, 32'd0,         64'hFFFF_FF9C_FFFF_FFFF, 4'd0);
    add_entry(FN_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000, 4'd0);
    add_entry(FN_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 64'h8000_0000_0000_0000, 4'd1);
  endfunction

  // lfsr operands, alternating mul/div/divu so requests run back to back
  function automatic void add_random_entries(input int count);
    imuldiv_fn_e     fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     hv;
    for (int i = 0; i < count; i++) begin
      case (i % 3)
        0:       fn = FN_MUL;
        1:       fn = FN_DIV;
        default: fn = FN_DIVU;
      endcase
      a = rand_bits(32);
      if (fn == FN_MUL) begin
        b = rand_bits(32);
      end else begin
        // small divisors give quotients with many bits set
        b = rand_bits(16);
        if (rand_bits(1) == 32'd1) begin
          b = -b;
        end
      end
      hv = rand_bits(2);
      add_entry(fn, a, b, expected_result(fn, a, b), hv[3:0]);
    end
  endfunction

  //----------------------------
  // one request/response transfer
  //----------------------------
  task automatic run_entry(input int idx, input tb_entry_t e);
    imuldiv_resp_t exp_resp;
    int            waits;
    int            lat;
    int            hold_n;
    exp_resp.result = e.exp;
    hold_n          = int'(e.hold);
    @(posedge clk);
    #1;
    req.fn  = e.fn;
    req.a   = e.a;
    req.b   = e.b;
    req_val = 1'b1;
    @(negedge clk);
    waits = 0;
    while (!req_rdy) begin
      if (waits == TIMEOUT) begin
        report_timeout(idx, "req_rdy");
        return;
      end
      waits++;
      @(negedge clk);
    end
    // request taken on this edge
    @(posedge clk);
    #1;
    req_val = 1'b0;
    @(negedge clk);
    // count edges until the response shows up
    lat = 0;
    while (!resp_val) begin
      check_bit(req_rdy, 1'b0, "req_rdy");
      if (lat == TIMEOUT) begin
        report_timeout(idx, "resp_val");
        return;
      end
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    check_count(lat, `IMULDIV_ITERS + 1, "resp latency");
    check_resp(resp, exp_resp, "resp");
    // back-pressure, a request for the other unit sits on the port meanwhile
    for (int h = 0; h < hold_n; h++) begin
      @(posedge clk);
      #1;
      req.fn  = (e.fn == FN_MUL) ? FN_DIV : FN_MUL;
      req_val = 1'b1;
      @(negedge clk);
      check_bit(resp_val, 1'b1, "resp_val");
      check_bit(req_rdy, 1'b0, "req_rdy");
      check_resp(resp, exp_resp, "resp");
    end
    @(posedge clk);
    #1;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    @(negedge clk);
    check_bit(resp_val, 1'b1, "resp_val");
    check_resp(resp, exp_resp, "resp");
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    @(negedge clk);
    // response gone, unit idle again
    check_bit(resp_val, 1'b0, "resp_val");
    check_bit(req_rdy, 1'b1, "req_rdy");
  endtask

  //----------------------------
  // main sequence
  //----------------------------
  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    lfsr_state   = 32'h8a26;
    err_count    = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    // idle state straight out of reset
    err_before = err_count;
    check_bit(req_rdy, 1'b1, "req_rdy");
    check_bit(resp_val, 1'b0, "resp_val");
    if (err_count != err_before) begin
      failed_tests++;
    end
    $display("test 0 reset: %s", (err_count == err_before) ? "ok" : "mismatch");
    add_fixed_entries();
    add_random_entries(12);
    for (int i = 0; i < table_q.size(); i++) begin
      err_before = err_count;
      run_entry(i + 1, table_q[i]);
      if (err_count != err_before || timed_out) begin
        failed_tests++;
      end
      $display("test %0d %s a=%h b=%h hold=%0d: %s", i + 1, fn_text(table_q[i].fn),
               table_q[i].a, table_q[i].b, table_q[i].hold,
               (err_count == err_before && !timed_out) ? "ok" : "mismatch");
      if (timed_out) begin
        break;
      end
    end
    $display("summary: %0d tests, %0d failed, %0d check errors",
             table_q.size() + 1, failed_tests, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
